// ==== tb.f ====
rtl/expipe_pkg.sv
rtl/mult_eu_if.sv
rtl/mult_rs.sv
rtl/mult.sv
rtl/mult_unit.sv
testbench/tb_mult_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the multiply unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f tb.f \
    --top-module tb_mult_unit --Mdir obj_dir -o tb_mult_unit

# The simulator exit status is not used; the log decides
./obj_dir/tb_mult_unit > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log

if grep -q "Testbench passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// ==== testbench/tb_mult_unit.sv ====
// Multiply unit testbench
// Directed tests for issue, operand wakeup, back-pressure, random traffic
// and flush, checked against a reference multiply per destination tag
`timescale 1ns/1ps

module tb_mult_unit;
    import expipe_pkg::*;

    localparam int RS_DEPTH    = 4;
    localparam int MULT_STAGES = 2;

    logic      clk_i = 1'b0;
    logic      rst_n_i;
    logic      flush_i;
    logic      issue_valid_i;
    logic      issue_ready_o;
    mult_ctl_t issue_ctl_i;
    logic      issue_rs1_rdy_i;
    rob_tag_t  issue_rs1_tag_i;
    data_t     issue_rs1_value_i;
    logic      issue_rs2_rdy_i;
    rob_tag_t  issue_rs2_tag_i;
    data_t     issue_rs2_value_i;
    rob_tag_t  issue_dest_tag_i;
    logic      cdb_valid_i;
    rob_tag_t  cdb_tag_i;
    data_t     cdb_value_i;
    logic      wb_valid_o;
    logic      wb_ready_i = 1'b0;
    rob_tag_t  wb_tag_o;
    data_t     wb_value_o;

    // Expected result per tag; a tag is outstanding while its counts differ
    data_t       exp_table [16];
    int          issued_cnt [16];
    int          taken_cnt [16];
    int          issued_total = 0;
    int          taken_total = 0;
    // Consumer mode 0 stalls, 1 is always ready, 2 is random
    int          wb_mode = 1;
    logic        stall_q = 1'b0;
    logic        flushed_q = 1'b0;
    rob_tag_t    held_tag;
    data_t       held_value;
    logic [31:0] stim_lfsr = 32'h46c3;
    logic [31:0] ready_lfsr = 32'h46c3;

    mult_unit #(
        .RS_DEPTH    (RS_DEPTH),
        .MULT_STAGES (MULT_STAGES)
    ) mult_unit_inst (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .flush_i           (flush_i),
        .issue_valid_i     (issue_valid_i),
        .issue_ready_o     (issue_ready_o),
        .issue_ctl_i       (issue_ctl_i),
        .issue_rs1_rdy_i   (issue_rs1_rdy_i),
        .issue_rs1_tag_i   (issue_rs1_tag_i),
        .issue_rs1_value_i (issue_rs1_value_i),
        .issue_rs2_rdy_i   (issue_rs2_rdy_i),
        .issue_rs2_tag_i   (issue_rs2_tag_i),
        .issue_rs2_value_i (issue_rs2_value_i),
        .issue_dest_tag_i  (issue_dest_tag_i),
        .cdb_valid_i       (cdb_valid_i),
        .cdb_tag_i         (cdb_tag_i),
        .cdb_value_i       (cdb_value_i),
        .wb_valid_o        (wb_valid_o),
        .wb_ready_i        (wb_ready_i),
        .wb_tag_o          (wb_tag_o),
        .wb_value_o        (wb_value_o)
    );

    // 8 ns clock
    always #4 clk_i = ~clk_i;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per stimulus bit taken
    function automatic logic [31:0] stim_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            r = {r[30:0], stim_lfsr[0]};
        end
        return r;
    endfunction

    // Reference multiply from the 64-bit product of extended operands
    function automatic data_t ref_mul(input mult_ctl_t ctl, input data_t a, input data_t b);
        logic [63:0] a_sx, b_sx, a_zx, b_zx, p;
        a_sx = {{32{a[31]}}, a};
        b_sx = {{32{b[31]}}, b};
        a_zx = {32'h0, a};
        b_zx = {32'h0, b};
        case (ctl)
            MULT_MUL:    p = a_zx * b_zx;
            MULT_MULH:   p = a_sx * b_sx;
            MULT_MULHSU: p = a_sx * b_zx;
            default:     p = a_zx * b_zx;
        endcase
        return (ctl == MULT_MUL) ? p[31:0] : p[63:32];
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            stop_run("Data value mismatch");
        end
    endtask

    task automatic check_tag(input string name, input rob_tag_t got, input rob_tag_t exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            stop_run("Tag mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            stop_run("Flag mismatch");
        end
    endtask

    always @(posedge clk_i) flushed_q <= flush_i;

    // Writeback consumer drives ready and checks stalls and taken results
    always @(negedge clk_i) begin
        if (rst_n_i) begin
            if (wb_mode == 2) begin
                ready_lfsr = lfsr_step(ready_lfsr);
                wb_ready_i = ready_lfsr[0];
            end else begin
                wb_ready_i = (wb_mode == 1);
            end
            // A stalled result must hold until taken, unless flushed
            if (stall_q && !flushed_q) begin
                check_bit("wb_valid_o", wb_valid_o, 1'b1);
                check_tag("wb_tag_o", wb_tag_o, held_tag);
                check_data("wb_value_o", wb_value_o, held_value);
            end
            if (wb_valid_o) begin
                if (issued_cnt[wb_tag_o] == taken_cnt[wb_tag_o]) begin
                    stop_run("Writeback of a tag that is not outstanding");
                end
                if (wb_ready_i) begin
                    check_data("wb_value_o", wb_value_o, exp_table[wb_tag_o]);
                    taken_cnt[wb_tag_o]++;
                    taken_total++;
                end
            end
            stall_q    = wb_valid_o && !wb_ready_i;
            held_tag   = wb_tag_o;
            held_value = wb_value_o;
        end
    end

    // Issue one multiply; operands not ready get junk values here
    task automatic issue_op(input mult_ctl_t ctl, input data_t a, input data_t b,
                            input logic a_rdy, input logic b_rdy,
                            input rob_tag_t src_tag, input rob_tag_t dest);
        int waited;
        waited = 0;
        while (!issue_ready_o || (issued_cnt[dest] != taken_cnt[dest])) begin
            @(negedge clk_i);
            waited++;
            if (waited > 1000) begin
                stop_run("Issue port or destination tag never became free");
            end
        end
        issue_valid_i     = 1'b1;
        issue_ctl_i       = ctl;
        issue_rs1_rdy_i   = a_rdy;
        issue_rs1_tag_i   = src_tag;
        issue_rs1_value_i = a_rdy ? a : stim_bits(32);
        issue_rs2_rdy_i   = b_rdy;
        // rs2 waits on the neighbouring tag
        issue_rs2_tag_i   = src_tag ^ 4'h1;
        issue_rs2_value_i = b_rdy ? b : stim_bits(32);
        issue_dest_tag_i  = dest;
        exp_table[dest]   = ref_mul(ctl, a, b);
        issued_cnt[dest]++;
        issued_total++;
        @(negedge clk_i);
        issue_valid_i = 1'b0;
    endtask

    task automatic broadcast(input rob_tag_t tag, input data_t value);
        cdb_valid_i = 1'b1;
        cdb_tag_i   = tag;
        cdb_value_i = value;
        @(negedge clk_i);
        cdb_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (issued_total != taken_total) begin
            @(negedge clk_i);
            waited++;
            if (waited > 2000) begin
                stop_run("Not all results were written back");
            end
        end
    endtask

    task automatic expect_quiet(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            check_bit("wb_valid_o", wb_valid_o, 1'b0);
            @(negedge clk_i);
        end
    endtask

    task automatic idle_after_reset();
        check_bit("wb_valid_o", wb_valid_o, 1'b0);
        check_bit("issue_ready_o", issue_ready_o, 1'b1);
    endtask

    // One of each operation with negative operands included
    task automatic each_op_writeback();
        issue_op(MULT_MUL, 32'd7, 32'hffff_fffd, 1'b1, 1'b1, 4'd0, 4'd1);
        issue_op(MULT_MULH, 32'hffff_fffb, 32'h8000_0000, 1'b1, 1'b1, 4'd0, 4'd2);
        issue_op(MULT_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 1'b1, 1'b1, 4'd0, 4'd3);
        issue_op(MULT_MULHU, 32'hffff_ffff, 32'hffff_ffff, 1'b1, 1'b1, 4'd0, 4'd4);
        wait_drain();
    endtask

    task automatic operand_wakeup();
        issue_op(MULT_MULHSU, 32'hdead_beef, 32'h1234_5678, 1'b0, 1'b1, 4'd9, 4'd5);
        expect_quiet(20);
        broadcast(4'd9, 32'hdead_beef);
        wait_drain();
    endtask

    // Fill every entry under back-pressure, then release
    task automatic full_station();
        wb_mode = 0;
        @(negedge clk_i);
        for (int k = 0; k < RS_DEPTH; k++) begin
            issue_op(mult_ctl_t'(k), stim_bits(32), stim_bits(32), 1'b1, 1'b1,
                     4'd0, rob_tag_t'(k));
        end
        check_bit("issue_ready_o", issue_ready_o, 1'b0);
        wb_mode = 1;
        wait_drain();
        @(negedge clk_i);
        check_bit("issue_ready_o", issue_ready_o, 1'b1);
    endtask

    task automatic random_stream();
        mult_ctl_t ctl;
        data_t     a, b;
        logic      a_rdy, b_rdy;
        rob_tag_t  src;
        wb_mode = 2;
        for (int n = 0; n < 40; n++) begin
            ctl   = mult_ctl_t'(stim_bits(2));
            a     = stim_bits(32);
            b     = stim_bits(32);
            a_rdy = (stim_bits(2) != 0);
            b_rdy = (stim_bits(2) != 0);
            src   = rob_tag_t'(stim_bits(4));
            issue_op(ctl, a, b, a_rdy, b_rdy, src, rob_tag_t'(n % 16));
            // Late producers broadcast after a short random delay
            if (!a_rdy) begin
                repeat (stim_bits(2)) @(negedge clk_i);
                broadcast(src, a);
            end
            if (!b_rdy) begin
                repeat (stim_bits(2)) @(negedge clk_i);
                broadcast(src ^ 4'h1, b);
            end
        end
        wait_drain();
        wb_mode = 1;
    endtask

    task automatic flush_drops_work();
        wb_mode = 0;
        @(negedge clk_i);
        for (int k = 0; k < 3; k++) begin
            issue_op(MULT_MUL, stim_bits(32), stim_bits(32), 1'b1, 1'b1,
                     4'd0, rob_tag_t'(10 + k));
        end
        repeat (6) @(negedge clk_i);
        flush_i = 1'b1;
        @(negedge clk_i);
        flush_i = 1'b0;
        // Flushed work is dropped
        for (int t = 0; t < 16; t++) begin
            issued_cnt[t] = taken_cnt[t];
        end
        issued_total = taken_total;
        wb_mode = 1;
        expect_quiet(20);
        check_bit("issue_ready_o", issue_ready_o, 1'b1);
    endtask

    initial begin
        rst_n_i           = 1'b0;
        flush_i           = 1'b0;
        issue_valid_i     = 1'b0;
        issue_ctl_i       = MULT_MUL;
        issue_rs1_rdy_i   = 1'b0;
        issue_rs1_tag_i   = '0;
        issue_rs1_value_i = '0;
        issue_rs2_rdy_i   = 1'b0;
        issue_rs2_tag_i   = '0;
        issue_rs2_value_i = '0;
        issue_dest_tag_i  = '0;
        cdb_valid_i       = 1'b0;
        cdb_tag_i         = '0;
        cdb_value_i       = '0;
        repeat (2) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        idle_after_reset();
        each_op_writeback();
        operand_wakeup();
        full_station();
        random_stream();
        flush_drops_work();
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== rtl/mult_unit.sv ====
// Multiply unit top level
// Reservation station and pipelined multiplier joined by their link
`timescale 1ns/1ps

module mult_unit #(
    parameter int RS_DEPTH    = 4,
    parameter int MULT_STAGES = 2
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    // Issue port
    input  logic                  issue_valid_i,
    output logic                  issue_ready_o,
    input  expipe_pkg::mult_ctl_t issue_ctl_i,
    input  logic                  issue_rs1_rdy_i,
    input  expipe_pkg::rob_tag_t  issue_rs1_tag_i,
    input  expipe_pkg::data_t     issue_rs1_value_i,
    input  logic                  issue_rs2_rdy_i,
    input  expipe_pkg::rob_tag_t  issue_rs2_tag_i,
    input  expipe_pkg::data_t     issue_rs2_value_i,
    input  expipe_pkg::rob_tag_t  issue_dest_tag_i,
    // Common data bus snoop
    input  logic                  cdb_valid_i,
    input  expipe_pkg::rob_tag_t  cdb_tag_i,
    input  expipe_pkg::data_t     cdb_value_i,
    // Writeback port
    output logic                  wb_valid_o,
    input  logic                  wb_ready_i,
    output expipe_pkg::rob_tag_t  wb_tag_o,
    output expipe_pkg::data_t     wb_value_o
);
    import expipe_pkg::*;

    // Index width shared by both ends of the link
    localparam int IDX_W = rs_idx_w(RS_DEPTH);

    mult_eu_if #(.IDX_W(IDX_W)) eu_link ();

    mult_rs #(
        .RS_DEPTH (RS_DEPTH)
    ) mult_rs_inst (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .flush_i           (flush_i),
        .issue_valid_i     (issue_valid_i),
        .issue_ready_o     (issue_ready_o),
        .issue_ctl_i       (issue_ctl_i),
        .issue_rs1_rdy_i   (issue_rs1_rdy_i),
        .issue_rs1_tag_i   (issue_rs1_tag_i),
        .issue_rs1_value_i (issue_rs1_value_i),
        .issue_rs2_rdy_i   (issue_rs2_rdy_i),
        .issue_rs2_tag_i   (issue_rs2_tag_i),
        .issue_rs2_value_i (issue_rs2_value_i),
        .issue_dest_tag_i  (issue_dest_tag_i),
        .cdb_valid_i       (cdb_valid_i),
        .cdb_tag_i         (cdb_tag_i),
        .cdb_value_i       (cdb_value_i),
        .wb_valid_o        (wb_valid_o),
        .wb_ready_i        (wb_ready_i),
        .wb_tag_o          (wb_tag_o),
        .wb_value_o        (wb_value_o),
        .eu                (eu_link.rs)
    );

    mult #(
        .RS_DEPTH    (RS_DEPTH),
        .MULT_STAGES (MULT_STAGES)
    ) mult_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .flush_i (flush_i),
        .eu      (eu_link.eu)
    );

endmodule

// ==== rtl/mult.sv ====
// Pipelined multiplier
// Handles MUL, MULH, MULHSU and MULHU, returns the result with the
// station entry index after MULT_STAGES cycles
`timescale 1ns/1ps

module mult #(
    parameter int RS_DEPTH    = 4,
    parameter int MULT_STAGES = 2
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic flush_i,
    mult_eu_if.eu eu
);
    import expipe_pkg::*;

    localparam int IDX_W = rs_idx_w(RS_DEPTH);

    // Input stage: operands extended to XLEN+1 bits
    logic                    in_valid_q;
    logic [IDX_W-1:0]        in_idx_q;
    logic signed [XLEN:0]    in_a_q;
    logic signed [XLEN:0]    in_b_q;
    logic                    in_hi_q;
    logic                    a_signed, b_signed;
    logic signed [2*XLEN+1:0] product;
    data_t                   prod_sel;

    // Result pipeline
    logic             st_valid_q [MULT_STAGES];
    logic [IDX_W-1:0] st_idx_q   [MULT_STAGES];
    data_t            st_value_q [MULT_STAGES];

    // rs1 is signed except for MULHU, rs2 only for MUL and MULH
    assign a_signed = (eu.disp_ctl != MULT_MULHU);
    assign b_signed = (eu.disp_ctl == MULT_MUL) || (eu.disp_ctl == MULT_MULH);

    // Signed 33x33 product, then pick the half
    assign product  = in_a_q * in_b_q;
    assign prod_sel = in_hi_q ? product[2*XLEN-1:XLEN] : product[XLEN-1:0];

    // Valid bits
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_valid_q <= 1'b0;
            for (int k = 0; k < MULT_STAGES; k++) begin
                st_valid_q[k] <= 1'b0;
            end
        end else if (flush_i) begin
            in_valid_q <= 1'b0;
            for (int k = 0; k < MULT_STAGES; k++) begin
                st_valid_q[k] <= 1'b0;
            end
        end else begin
            in_valid_q    <= eu.disp_valid;
            st_valid_q[0] <= in_valid_q;
            for (int k = 1; k < MULT_STAGES; k++) begin
                st_valid_q[k] <= st_valid_q[k-1];
            end
        end
    end

    // Operands, index and result travel alongside the valid bits
    always_ff @(posedge clk_i) begin
        in_idx_q      <= eu.disp_idx;
        in_a_q        <= {a_signed & eu.disp_rs1[XLEN-1], eu.disp_rs1};
        in_b_q        <= {b_signed & eu.disp_rs2[XLEN-1], eu.disp_rs2};
        in_hi_q       <= (eu.disp_ctl != MULT_MUL);
        st_idx_q[0]   <= in_idx_q;
        st_value_q[0] <= prod_sel;
        for (int k = 1; k < MULT_STAGES; k++) begin
            st_idx_q[k]   <= st_idx_q[k-1];
            st_value_q[k] <= st_value_q[k-1];
        end
    end

    // Last stage returns to the station
    assign eu.res_valid = st_valid_q[MULT_STAGES-1];
    assign eu.res_idx   = st_idx_q[MULT_STAGES-1];
    assign eu.res_value = st_value_q[MULT_STAGES-1];

endmodule

// ==== rtl/mult_rs.sv ====
// Multiply reservation station
// Holds issued multiplies, snoops the data bus for missing operands,
// dispatches ready entries and writes finished results back
`timescale 1ns/1ps

module mult_rs #(
    parameter int RS_DEPTH = 4
) (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,
    // Issue port
    input  logic                  issue_valid_i,
    output logic                  issue_ready_o,
    input  expipe_pkg::mult_ctl_t issue_ctl_i,
    input  logic                  issue_rs1_rdy_i,
    input  expipe_pkg::rob_tag_t  issue_rs1_tag_i,
    input  expipe_pkg::data_t     issue_rs1_value_i,
    input  logic                  issue_rs2_rdy_i,
    input  expipe_pkg::rob_tag_t  issue_rs2_tag_i,
    input  expipe_pkg::data_t     issue_rs2_value_i,
    input  expipe_pkg::rob_tag_t  issue_dest_tag_i,
    // Common data bus snoop
    input  logic                  cdb_valid_i,
    input  expipe_pkg::rob_tag_t  cdb_tag_i,
    input  expipe_pkg::data_t     cdb_value_i,
    // Writeback port
    output logic                  wb_valid_o,
    input  logic                  wb_ready_i,
    output expipe_pkg::rob_tag_t  wb_tag_o,
    output expipe_pkg::data_t     wb_value_o,
    // Multiplier link
    mult_eu_if.rs                 eu
);
    import expipe_pkg::*;

    localparam int IDX_W = rs_idx_w(RS_DEPTH);
    typedef logic [IDX_W-1:0] idx_t;

    // Entry storage
    rs_state_t state_q    [RS_DEPTH];
    mult_ctl_t ctl_q      [RS_DEPTH];
    logic      rs1_rdy_q  [RS_DEPTH];
    rob_tag_t  rs1_tag_q  [RS_DEPTH];
    data_t     rs1_val_q  [RS_DEPTH];
    logic      rs2_rdy_q  [RS_DEPTH];
    rob_tag_t  rs2_tag_q  [RS_DEPTH];
    data_t     rs2_val_q  [RS_DEPTH];
    rob_tag_t  dest_tag_q [RS_DEPTH];
    data_t     result_q   [RS_DEPTH];

    // Data bus matches on waiting operands
    logic cdb_hit1 [RS_DEPTH];
    logic cdb_hit2 [RS_DEPTH];

    idx_t  free_idx, disp_idx, done_idx, wb_sel_idx, wb_held_idx_q;
    logic  free_found, disp_found, done_found, wb_held_q;
    logic  issue_accept, wb_take;
    logic  new_rs1_rdy, new_rs2_rdy;
    data_t new_rs1_val, new_rs2_val;

    // Lowest-index pickers: free slot, ready entry, finished entry
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        disp_found = 1'b0;
        disp_idx   = '0;
        done_found = 1'b0;
        done_idx   = '0;
        // Walk downwards so the lowest match is kept
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (state_q[i] == RS_EMPTY) begin
                free_found = 1'b1;
                free_idx   = idx_t'(i);
            end
            if (state_q[i] == RS_READY) begin
                disp_found = 1'b1;
                disp_idx   = idx_t'(i);
            end
            if (state_q[i] == RS_DONE) begin
                done_found = 1'b1;
                done_idx   = idx_t'(i);
            end
        end
    end

    // Snoop: a broadcast fills any operand still waiting on its tag
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            cdb_hit1[i] = cdb_valid_i && !rs1_rdy_q[i] && (cdb_tag_i == rs1_tag_q[i]);
            cdb_hit2[i] = cdb_valid_i && !rs2_rdy_q[i] && (cdb_tag_i == rs2_tag_q[i]);
        end
    end

    // Issue with same-cycle bus forwarding
    assign issue_ready_o = free_found;
    assign issue_accept  = issue_valid_i && free_found;
    assign new_rs1_rdy   = issue_rs1_rdy_i || (cdb_valid_i && (cdb_tag_i == issue_rs1_tag_i));
    assign new_rs2_rdy   = issue_rs2_rdy_i || (cdb_valid_i && (cdb_tag_i == issue_rs2_tag_i));
    assign new_rs1_val   = issue_rs1_rdy_i ? issue_rs1_value_i : cdb_value_i;
    assign new_rs2_val   = issue_rs2_rdy_i ? issue_rs2_value_i : cdb_value_i;

    // Dispatch toward the multiplier
    assign eu.disp_valid = disp_found;
    assign eu.disp_idx   = disp_idx;
    assign eu.disp_ctl   = ctl_q[disp_idx];
    assign eu.disp_rs1   = rs1_val_q[disp_idx];
    assign eu.disp_rs2   = rs2_val_q[disp_idx];

    // Writeback holds its entry once stalled, so a lower entry
    // finishing later cannot swap the presented result
    assign wb_sel_idx = wb_held_q ? wb_held_idx_q : done_idx;
    assign wb_valid_o = wb_held_q || done_found;
    assign wb_tag_o   = dest_tag_q[wb_sel_idx];
    assign wb_value_o = result_q[wb_sel_idx];
    assign wb_take    = wb_valid_o && wb_ready_i;

    // Entry state machines
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                state_q[i] <= RS_EMPTY;
            end
            wb_held_q <= 1'b0;
        end else if (flush_i) begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                state_q[i] <= RS_EMPTY;
            end
            wb_held_q <= 1'b0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                case (state_q[i])
                    RS_EMPTY: begin
                        if (issue_accept && (free_idx == idx_t'(i))) begin
                            state_q[i] <= (new_rs1_rdy && new_rs2_rdy) ? RS_READY : RS_WAIT_OPS;
                        end
                    end
                    RS_WAIT_OPS: begin
                        if ((rs1_rdy_q[i] || cdb_hit1[i]) && (rs2_rdy_q[i] || cdb_hit2[i])) begin
                            state_q[i] <= RS_READY;
                        end
                    end
                    RS_READY: begin
                        if (disp_found && (disp_idx == idx_t'(i))) begin
                            state_q[i] <= RS_EXEC;
                        end
                    end
                    RS_EXEC: begin
                        if (eu.res_valid && (eu.res_idx == idx_t'(i))) begin
                            state_q[i] <= RS_DONE;
                        end
                    end
                    RS_DONE: begin
                        if (wb_take && (wb_sel_idx == idx_t'(i))) begin
                            state_q[i] <= RS_EMPTY;
                        end
                    end
                    default: state_q[i] <= RS_EMPTY;
                endcase
            end
            wb_held_q <= wb_valid_o && !wb_ready_i;
        end
    end

    // Entry payload
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (issue_accept && (free_idx == idx_t'(i))) begin
                ctl_q[i]      <= issue_ctl_i;
                rs1_rdy_q[i]  <= new_rs1_rdy;
                rs1_tag_q[i]  <= issue_rs1_tag_i;
                rs1_val_q[i]  <= new_rs1_val;
                rs2_rdy_q[i]  <= new_rs2_rdy;
                rs2_tag_q[i]  <= issue_rs2_tag_i;
                rs2_val_q[i]  <= new_rs2_val;
                dest_tag_q[i] <= issue_dest_tag_i;
            end else begin
                if (cdb_hit1[i]) begin
                    rs1_rdy_q[i] <= 1'b1;
                    rs1_val_q[i] <= cdb_value_i;
                end
                if (cdb_hit2[i]) begin
                    rs2_rdy_q[i] <= 1'b1;
                    rs2_val_q[i] <= cdb_value_i;
                end
            end
            // Result lands in the entry named by the multiplier
            if (eu.res_valid && (eu.res_idx == idx_t'(i))) begin
                result_q[i] <= eu.res_value;
            end
        end
        wb_held_idx_q <= wb_sel_idx;
    end

endmodule

// ==== rtl/mult_eu_if.sv ====
// Station to multiplier link
// Dispatches go out with the entry index, results come back with it
`timescale 1ns/1ps

interface mult_eu_if #(
    parameter int IDX_W = 2
) ();
    import expipe_pkg::*;

    // Dispatch side, driven by the station
    logic             disp_valid;
    mult_ctl_t        disp_ctl;
    data_t            disp_rs1;
    data_t            disp_rs2;
    logic [IDX_W-1:0] disp_idx;

    // Result side, driven by the multiplier
    logic             res_valid;
    logic [IDX_W-1:0] res_idx;
    data_t            res_value;

    // Reservation station view
    modport rs (
        output disp_valid, disp_ctl, disp_rs1, disp_rs2, disp_idx,
        input  res_valid, res_idx, res_value
    );

    // Execution unit view
    modport eu (
        input  disp_valid, disp_ctl, disp_rs1, disp_rs2, disp_idx,
        output res_valid, res_idx, res_value
    );

endinterface

// ==== rtl/expipe_pkg.sv ====
// Execution pipeline package
// Shared widths, tag and control types, multiply operation codes
// and the reservation station entry states
package expipe_pkg;

    // Operand and result width
    localparam int XLEN = 32;

    // Operand and result data
    typedef logic [XLEN-1:0] data_t;

    // Reorder buffer tag: producer of an operand, destination of a result
    typedef logic [3:0] rob_tag_t;

    // Multiply operation code
    typedef logic [1:0] mult_ctl_t;

    // Low half of the product
    localparam mult_ctl_t MULT_MUL    = 2'd0;
    // High half, signed x signed
    localparam mult_ctl_t MULT_MULH   = 2'd1;
    // High half, signed rs1 x unsigned rs2
    localparam mult_ctl_t MULT_MULHSU = 2'd2;
    // High half, unsigned x unsigned
    localparam mult_ctl_t MULT_MULHU  = 2'd3;

    // Reservation station entry state
    typedef enum logic [2:0] {
        RS_EMPTY,
        RS_WAIT_OPS,
        RS_READY,
        RS_EXEC,
        RS_DONE
    } rs_state_t;

    // Entry index width, never below one bit
    function automatic int rs_idx_w(input int depth);
        return (depth > 1) ? $clog2(depth) : 1;
    endfunction

endpackage
